//--- Bender.yml
package:
  name: i2c_master

sources:
  - include_dirs:
      - .
    files:
      - i2c_pkg.sv
      - req_fifo.sv
      - i2c_bit_engine.sv
      - i2c_txn_ctrl.sv
      - i2c_master_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_i2c_slave_model.sv
      - tb_i2c_master.sv

//--- flist.f
+incdir+.
i2c_pkg.sv
req_fifo.sv
i2c_bit_engine.sv
i2c_txn_ctrl.sv
i2c_master_top.sv
tb_i2c_slave_model.sv
tb_i2c_master.sv

//--- i2c_bit_engine.sv
// I2C bit engine: quarter-period tick, start/restart/stop conditions,
// byte shift out and in with the acknowledge slot, open-drain SDA

`include "i2c_params.svh"

module i2c_bit_engine
    import i2c_pkg::*;
(
    input  logic      dri_clk,
    input  logic      rst_n,
    input  logic      op_valid,
    input  i2c_op_e   op,
    input  i2c_byte_t op_byte,
    output logic      op_ready,
    output logic      op_done,
    output i2c_byte_t op_rdata,
    output logic      scl,
    inout  wire       sda
);

    localparam int DIV_W = $clog2(`I2C_QUARTER_DIV) + 1;

    logic [DIV_W-1:0] tick_cnt;
    logic             tick;         // quarter SCL period enable
    logic             busy;
    logic [5:0]       step;         // quarter step within the op
    logic [5:0]       last_step;
    logic [3:0]       bit_idx;      // 0..7 data, 8 = ack slot
    logic [1:0]       phase;
    logic             byte_op;
    i2c_op_e          cur_op;
    i2c_byte_t        tx_sh;
    i2c_byte_t        rx_sh;
    logic             sda_out;      // 1 releases the line

    assign sda       = sda_out ? 1'bz : 1'b0;
    assign op_ready  = ~busy;
    assign op_rdata  = rx_sh;
    assign tick      = busy && (tick_cnt == DIV_W'(`I2C_QUARTER_DIV - 1));
    assign byte_op   = (cur_op == OP_WRITE) || (cur_op == OP_READ);
    assign last_step = byte_op ? 6'd35 : 6'd3;
    assign bit_idx   = step[5:2];
    assign phase     = step[1:0];

    // ------------------------------------------------------------------
    // quarter tick divider, restarts with every new op
    // ------------------------------------------------------------------
    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            tick_cnt <= '0;
        end else if (!busy || tick) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // step sequencing and line drive
    // each bit: set data, raise SCL, hold, lower SCL
    // ------------------------------------------------------------------
    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            step    <= '0;
            cur_op  <= OP_STOP;
            op_done <= 1'b0;
            scl     <= 1'b1;                        // bus released
            sda_out <= 1'b1;
        end else begin
            op_done <= 1'b0;
            if (op_valid && !busy) begin
                busy   <= 1'b1;
                step   <= '0;
                cur_op <= op;
            end else if (tick) begin
                step <= step + 1'b1;
                if (step == last_step) begin
                    busy    <= 1'b0;
                    op_done <= 1'b1;
                end
                case (cur_op)
                    OP_START: begin
                        case (phase)
                            2'd0: begin
                                scl     <= 1'b1;
                                sda_out <= 1'b1;
                            end
                            2'd1:    sda_out <= 1'b0;   // SDA falls, SCL high
                            2'd3:    scl     <= 1'b0;
                            default: ;
                        endcase
                    end
                    OP_RESTART: begin
                        case (phase)
                            2'd0:    sda_out <= 1'b1;
                            2'd1:    scl     <= 1'b1;
                            2'd2:    sda_out <= 1'b0;   // repeated start
                            default: scl     <= 1'b0;
                        endcase
                    end
                    OP_STOP: begin
                        case (phase)
                            2'd0:    sda_out <= 1'b0;
                            2'd1:    scl     <= 1'b1;
                            2'd3:    sda_out <= 1'b1;   // SDA rises, SCL high
                            default: ;
                        endcase
                    end
                    default: begin
                        case (phase)
                            // ack slot released, read nack is a released line
                            2'd0: sda_out <= (cur_op == OP_WRITE && bit_idx != 4'd8) ?
                                             tx_sh[7] : 1'b1;
                            2'd1:    scl <= 1'b1;
                            2'd3:    scl <= 1'b0;
                            default: ;
                        endcase
                    end
                endcase
            end
        end
    end

    // shift registers, msb first
    always_ff @(posedge dri_clk) begin
        if (op_valid && !busy) begin
            tx_sh <= op_byte;
        end else if (tick && cur_op == OP_WRITE && phase == 2'd3) begin
            tx_sh <= {tx_sh[6:0], 1'b0};
        end
        if (tick && cur_op == OP_READ && phase == 2'd1 && bit_idx != 4'd8) begin
            rx_sh <= {rx_sh[6:0], sda};             // sample at SCL rise
        end
    end

endmodule

//--- i2c_cases.txt
// columns: rd (1 = read) addr16 (1 = 16-bit address) address data
// data is the write byte, or the expected byte for a read
0 0 0012 a5
1 0 0012 a5
0 1 3412 5c
0 1 7712 c3
1 1 3412 5c
1 1 7712 c3
0 1 0040 9e
1 0 0040 9e
0 0 0040 11
1 1 0040 11
1 0 0012 a5
1 1 7712 c3

//--- i2c_master_top.sv
// I2C EEPROM master top level
// request FIFO, sequencer, bit engine and read data FIFO

`include "i2c_params.svh"

module i2c_master_top
    import i2c_pkg::*;
(
    input  logic      dri_clk,
    input  logic      rst_n,
    input  logic      req_valid,
    output logic      req_ready,
    input  i2c_req_t  req,
    output logic      rsp_valid,
    input  logic      rsp_ready,
    output i2c_byte_t rsp_data,
    output logic      done,
    output logic      scl,
    inout  wire       sda
);

    logic      q_valid;         // request FIFO to sequencer
    logic      q_ready;
    i2c_req_t  q_req;
    logic      op_valid;
    logic      op_ready;
    i2c_op_e   op;
    i2c_byte_t op_byte;
    logic      op_done;
    i2c_byte_t op_rdata;
    logic      push_valid;      // sequencer to read data FIFO
    logic      push_ready;
    i2c_byte_t push_data;

    req_fifo #(
        .payload_t (i2c_req_t),
        .DEPTH     (`I2C_REQ_DEPTH)
    ) i_req_fifo (
        .dri_clk   (dri_clk),
        .rst_n     (rst_n),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .in_data   (req),
        .out_valid (q_valid),
        .out_ready (q_ready),
        .out_data  (q_req)
    );

    i2c_txn_ctrl i_i2c_txn_ctrl (
        .dri_clk   (dri_clk),
        .rst_n     (rst_n),
        .req_valid (q_valid),
        .req_ready (q_ready),
        .req       (q_req),
        .op_valid  (op_valid),
        .op_ready  (op_ready),
        .op        (op),
        .op_byte   (op_byte),
        .op_done   (op_done),
        .op_rdata  (op_rdata),
        .rsp_valid (push_valid),
        .rsp_ready (push_ready),
        .rsp_data  (push_data),
        .done      (done)
    );

    i2c_bit_engine i_i2c_bit_engine (
        .dri_clk  (dri_clk),
        .rst_n    (rst_n),
        .op_valid (op_valid),
        .op       (op),
        .op_byte  (op_byte),
        .op_ready (op_ready),
        .op_done  (op_done),
        .op_rdata (op_rdata),
        .scl      (scl),
        .sda      (sda)
    );

    req_fifo #(
        .payload_t (i2c_byte_t),
        .DEPTH     (`I2C_RSP_DEPTH)
    ) i_rsp_fifo (
        .dri_clk   (dri_clk),
        .rst_n     (rst_n),
        .in_valid  (push_valid),
        .in_ready  (push_ready),
        .in_data   (push_data),
        .out_valid (rsp_valid),
        .out_ready (rsp_ready),
        .out_data  (rsp_data)
    );

endmodule

//--- i2c_params.svh
// build-time constants for the I2C master
// slave address, SCL clock ratio and FIFO depths

`ifndef I2C_PARAMS_SVH
`define I2C_PARAMS_SVH

// ----------------------------------------------------------------------
// bus settings
// ----------------------------------------------------------------------
`define I2C_SLAVE_ADDR  7'b1010000  // 7-bit EEPROM device address

// dri_clk cycles per quarter SCL period, CLK_FREQ / I2C_FREQ / 4
`define I2C_QUARTER_DIV 5           // kept small for simulation

// ----------------------------------------------------------------------
// queue sizes
// ----------------------------------------------------------------------
`define I2C_REQ_DEPTH   4           // pending host requests
`define I2C_RSP_DEPTH   4           // read bytes waiting for the host

`endif

//--- i2c_pkg.sv
// shared types for the I2C master
// data and address widths, host request record, bit engine op codes

package i2c_pkg;

    typedef logic [7:0]  i2c_byte_t;    // one data byte on the bus
    typedef logic [15:0] i2c_addr_t;    // EEPROM word address

    // one host transaction
    typedef struct packed {
        logic      rd;                  // 1 = random read, 0 = byte write
        logic      addr16;              // send high address byte too
        i2c_addr_t addr;
        i2c_byte_t wdata;               // ignored on reads
    } i2c_req_t;

    // operations the sequencer hands to the bit engine
    typedef enum logic [2:0] {
        OP_START,                       // start from idle bus
        OP_RESTART,                     // repeated start, SCL low on entry
        OP_WRITE,                       // 8 bits out plus ack slot
        OP_READ,                        // 8 bits in plus master nack
        OP_STOP                         // stop, bus left idle
    } i2c_op_e;

endpackage

//--- i2c_txn_ctrl.sv
// transaction sequencer: turns one EEPROM request into bit engine ops
// start, address bytes, write or restart plus read, stop

`include "i2c_params.svh"

module i2c_txn_ctrl
    import i2c_pkg::*;
(
    input  logic      dri_clk,
    input  logic      rst_n,
    input  logic      req_valid,
    output logic      req_ready,
    input  i2c_req_t  req,
    output logic      op_valid,
    input  logic      op_ready,
    output i2c_op_e   op,
    output i2c_byte_t op_byte,
    input  logic      op_done,
    input  i2c_byte_t op_rdata,
    output logic      rsp_valid,
    input  logic      rsp_ready,
    output i2c_byte_t rsp_data,
    output logic      done
);

    typedef enum logic [3:0] {
        ST_IDLE, ST_START, ST_SLA_W, ST_ADDR_HI, ST_ADDR_LO,
        ST_WDATA, ST_RESTART, ST_SLA_R, ST_RDATA, ST_STOP
    } state_e;

    state_e   state;
    state_e   nxt;
    i2c_req_t cur_req;
    logic     rd_hold;      // read op waits for room in the response FIFO

    function automatic state_e next_of(input state_e s, input i2c_req_t r);
        case (s)
            ST_START:   return ST_SLA_W;
            ST_SLA_W:   return r.addr16 ? ST_ADDR_HI : ST_ADDR_LO;
            ST_ADDR_HI: return ST_ADDR_LO;
            ST_ADDR_LO: return r.rd ? ST_RESTART : ST_WDATA;
            ST_WDATA:   return ST_STOP;
            ST_RESTART: return ST_SLA_R;
            ST_SLA_R:   return ST_RDATA;
            ST_RDATA:   return ST_STOP;
            default:    return ST_IDLE;
        endcase
    endfunction

    assign nxt       = next_of(state, cur_req);
    assign req_ready = (state == ST_IDLE);
    assign rsp_valid = op_done && (state == ST_RDATA);
    assign rsp_data  = op_rdata;

    // op and byte follow the state
    always_comb begin
        case (state)
            ST_START:   op = OP_START;
            ST_RESTART: op = OP_RESTART;
            ST_RDATA:   op = OP_READ;
            ST_STOP:    op = OP_STOP;
            default:    op = OP_WRITE;
        endcase
        case (state)
            ST_SLA_W:   op_byte = {`I2C_SLAVE_ADDR, 1'b0};
            ST_ADDR_HI: op_byte = cur_req.addr[15:8];
            ST_ADDR_LO: op_byte = cur_req.addr[7:0];
            ST_WDATA:   op_byte = cur_req.wdata;
            ST_SLA_R:   op_byte = {`I2C_SLAVE_ADDR, 1'b1};
            default:    op_byte = 8'h00;
        endcase
    end

    // ------------------------------------------------------------------
    // state and op issue, next op one cycle after op_done
    // ------------------------------------------------------------------
    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            op_valid <= 1'b0;
            rd_hold  <= 1'b0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (op_valid && op_ready) op_valid <= 1'b0;
            if (req_valid && req_ready) begin
                state    <= ST_START;
                op_valid <= 1'b1;
            end else if (op_done) begin
                state <= nxt;
                if (state == ST_STOP) begin
                    done <= 1'b1;                   // transaction over
                end else if (nxt == ST_RDATA && !rsp_ready) begin
                    rd_hold <= 1'b1;
                end else begin
                    op_valid <= 1'b1;
                end
            end else if (rd_hold && rsp_ready) begin
                rd_hold  <= 1'b0;
                op_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge dri_clk) begin
        if (req_valid && req_ready) cur_req <= req;
    end

endmodule

//--- req_fifo.sv
// synchronous circular-buffer FIFO with a type-parameter payload
// valid/ready on both sides, used for requests and for read bytes

module req_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     dri_clk,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;        // entries held
    logic             push;
    logic             pop;

    // wrap at DEPTH, so any depth works
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= ptr_inc(wr_ptr);
            if (pop) rd_ptr <= ptr_inc(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;                          // none or both
            endcase
        end
    end

    always_ff @(posedge dri_clk) begin
        if (push) mem[wr_ptr] <= in_data;
    end

endmodule

//--- tb_i2c_master.sv
// testbench for the I2C EEPROM master
// clock and reset, case file reader, host request driver, response checker and watchdog

`include "i2c_params.svh"

module tb_i2c_master
    import i2c_pkg::*;
;

    localparam int MAX_CASES = 32;
    localparam int PERIOD    = 4;

    logic      dri_clk;
    logic      rst_n;
    logic      req_valid;
    logic      req_ready;
    i2c_req_t  req;
    logic      rsp_valid;
    logic      rsp_ready;
    i2c_byte_t rsp_data;
    logic      done;
    logic      scl;
    logic      slave_err;
    tri1       sda;                 // bus pull-up

    logic [15:0] case_words [4*MAX_CASES];
    i2c_req_t    cases [$];
    i2c_byte_t   rd_exp [$];        // read bytes in bus order
    i2c_byte_t   exp_mem [int];
    int          n_cases;
    int          n_reads;
    int          rd_left;
    int          pushes;
    int          done_cnt;
    int          stall_left;
    logic        saw_full;
    logic        loaded;

    i2c_master_top i_i2c_master_top (
        .dri_clk   (dri_clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_data  (rsp_data),
        .done      (done),
        .scl       (scl),
        .sda       (sda)
    );

    tb_i2c_slave_model i_slave (
        .scl       (scl),
        .sda       (sda),
        .proto_err (slave_err)
    );

    initial begin
        dri_clk = 1'b0;
        forever #(PERIOD / 2) dri_clk = ~dri_clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            $display("ERR time=%0t %s actual=%h expected=%h", $time, name, act, exp);
            fail_run("value mismatch");
        end
    endtask

    // ------------------------------------------------------------------
    // case file reader with four hex words per case (rd addr16 addr data)
    // ------------------------------------------------------------------
    task automatic load_cases();
        i2c_req_t  r;
        logic [15:0] a;
        $readmemh("i2c_cases.txt", case_words);
        n_cases = 0;
        while (n_cases < MAX_CASES && case_words[4*n_cases] !== 16'hxxxx) begin
            r.rd     = case_words[4*n_cases][0];
            r.addr16 = case_words[4*n_cases+1][0];
            r.addr   = case_words[4*n_cases+2];
            r.wdata  = case_words[4*n_cases+3][7:0];
            a = r.addr16 ? r.addr : {8'h00, r.addr[7:0]};  // 8-bit access has high byte zero
            if (!r.rd) begin
                exp_mem[a] = r.wdata;
            end else if (exp_mem.exists(a)) begin
                check("case_file_rdata", r.wdata, exp_mem[a]);
                rd_exp.push_back(r.wdata);
            end else begin
                fail_run("case file reads an address that no earlier case wrote");
            end
            cases.push_back(r);
            n_cases++;
        end
        if (n_cases == 0) fail_run("case file holds no cases");
        n_reads = rd_exp.size();
        rd_left = n_reads;
    endtask

    task automatic push_request(input i2c_req_t r);
        logic taken;
        req_valid = 1'b1;
        req       = r;
        do begin
            taken = req_ready;
            if (!taken) begin
                saw_full = 1'b1;
                check("pending_when_full", (pushes - done_cnt) >= `I2C_REQ_DEPTH, 1);
            end
            @(negedge dri_clk);
        end while (!taken);
        pushes++;
        req_valid = 1'b0;
    endtask

    initial begin
        void'($urandom(46167));
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        rsp_ready = 1'b0;
        pushes    = 0;
        done_cnt  = 0;
        saw_full  = 1'b0;
        loaded    = 1'b0;
        load_cases();
        loaded = 1'b1;
        repeat (5) @(negedge dri_clk);
        check("scl", scl, 1);
        check("sda", sda, 1);
        check("done", done, 0);
        check("rsp_valid", rsp_valid, 0);
        rst_n = 1'b1;
        @(negedge dri_clk);
        check("req_ready", req_ready, 1);
        for (int i = 0; i < n_cases; i++) begin
            // first cases back to back to fill the request FIFO
            if (i >= 8) repeat ($urandom_range(300, 0)) @(negedge dri_clk);
            push_request(cases[i]);
        end
        wait (done_cnt == n_cases && rd_left == 0);
        @(negedge dri_clk);
        check("req_ready_dropped", saw_full, 1);
        check("slave_read_txns", i_slave.rd_txns, n_reads);
        check("slave_write_txns", i_slave.wr_txns, n_cases - n_reads);
        $display("TEST PASSED");
        $finish;
    end

    // ------------------------------------------------------------------
    // done counter, response stalls and read data check
    // ------------------------------------------------------------------
    always @(negedge dri_clk) begin
        if (rst_n) begin
            if (done) begin
                done_cnt++;
                check("done_count", done_cnt, i_slave.wr_txns + i_slave.rd_txns);
            end
            if (stall_left == 0) begin
                rsp_ready  = ~rsp_ready;
                stall_left = rsp_ready ? 1 + $urandom_range(3, 0) : $urandom_range(1500, 0);
            end else begin
                stall_left--;
            end
            if (rsp_valid && rsp_ready) begin
                if (rd_left == 0) fail_run("read byte returned with none expected");
                check("rsp_data", rsp_data, rd_exp.pop_front());
                rd_left--;
            end
        end else begin
            stall_left = 0;
        end
    end

    always @(posedge slave_err) begin
        fail_run("slave model saw a protocol violation on the bus");
    end

    // 40 bit periods per case with fourfold margin
    initial begin
        wait (loaded);
        #(n_cases * 40 * 4 * `I2C_QUARTER_DIV * 4 * PERIOD);
        fail_run("timeout, transactions did not complete");
    end

endmodule

//--- tb_i2c_slave_model.sv
// behavioral EEPROM slave on SCL/SDA with a 64K byte memory
// acknowledges its address, checks start/stop framing and address bytes

`include "i2c_params.svh"

module tb_i2c_slave_model (
    input  logic scl,
    inout  wire  sda,
    output logic proto_err
);

    typedef enum {M_IDLE, M_SLA, M_WR, M_RD, M_RD_DONE} mode_e;

    logic [7:0]  mem [65536];
    logic [7:0]  wr_q [$];      // address bytes, then write data
    mode_e       mode;
    int          bitcnt;
    int          wr_txns;
    int          rd_txns;
    logic [7:0]  sh;
    logic [7:0]  tx;
    logic [15:0] addr;
    logic        drv;           // 1 pulls SDA low
    logic        restarted;

    assign sda = drv ? 1'b0 : 1'bz;

    task automatic violation(input string msg);
        $display("slave model: %s at time %0t", msg, $time);
        proto_err = 1'b1;
    endtask

    function automatic logic [15:0] queued_addr();
        if (wr_q.size() == 1) return {8'h00, wr_q[0]};
        return {wr_q[0], wr_q[1]};
    endfunction

    initial begin
        for (int i = 0; i < 65536; i++) begin
            mem[i] = i[7:0] ^ i[15:8] ^ 8'h5a;      // whole-address pattern
        end
        mode      = M_IDLE;
        bitcnt    = 0;
        drv       = 1'b0;
        restarted = 1'b0;
        proto_err = 1'b0;
        wr_txns   = 0;
        rd_txns   = 0;
    end

    // ------------------------------------------------------------------
    // start and stop conditions
    // ------------------------------------------------------------------
    always @(negedge sda) begin
        if (scl === 1'b1) begin
            if (mode == M_IDLE) begin
                restarted = 1'b0;
            end else if (mode == M_WR && (wr_q.size() == 1 || wr_q.size() == 2)) begin
                restarted = 1'b1;                   // repeated start for a read
            end else begin
                violation("start condition in the middle of a transfer");
            end
            mode   = M_SLA;
            bitcnt = 0;
            drv    = 1'b0;
        end
    end

    always @(posedge sda) begin
        if (scl === 1'b1) begin
            case (mode)
                M_IDLE: ;                           // bus idle at power-up
                M_WR: begin
                    if (wr_q.size() == 2) begin
                        mem[{8'h00, wr_q[0]}] = wr_q[1];
                        wr_txns++;
                    end else if (wr_q.size() == 3) begin
                        mem[{wr_q[0], wr_q[1]}] = wr_q[2];
                        wr_txns++;
                    end else begin
                        violation("stop after a write with a wrong byte count");
                    end
                end
                M_RD_DONE: ;
                default: violation("stop before the transfer was complete");
            endcase
            mode = M_IDLE;
        end
    end

    // ------------------------------------------------------------------
    // bit level
    // ------------------------------------------------------------------
    always @(posedge scl) begin
        if (bitcnt < 8) begin
            sh     = {sh[6:0], sda};
            bitcnt = bitcnt + 1;
        end else if (bitcnt == 8) begin
            if (mode == M_RD_DONE && sda !== 1'b1) violation("master acknowledged a read byte");
            bitcnt = 9;
        end
    end

    always @(negedge scl) begin
        if (mode != M_IDLE) begin
            if (bitcnt == 8) begin
                case (mode)
                    M_SLA: begin
                        if (sh[7:1] != `I2C_SLAVE_ADDR) begin
                            violation("address byte does not carry the slave address");
                        end else if (sh[0] != restarted) begin
                            violation("wrong read/write bit in the address byte");
                        end else if (restarted) begin
                            addr = queued_addr();
                            tx   = mem[addr];
                            mode = M_RD;
                            rd_txns++;
                        end else begin
                            wr_q.delete();
                            mode = M_WR;
                        end
                        drv = 1'b1;
                    end
                    M_WR: begin
                        wr_q.push_back(sh);
                        if (wr_q.size() > 3) violation("too many bytes in a write");
                        drv = 1'b1;
                    end
                    M_RD: begin
                        drv  = 1'b0;                // master drives the nack
                        mode = M_RD_DONE;
                    end
                    default: drv = 1'b0;
                endcase
            end else if (bitcnt == 9) begin
                bitcnt = 0;
                drv    = (mode == M_RD) ? ~tx[7] : 1'b0;
            end else if (mode == M_RD) begin
                drv = ~tx[7 - bitcnt];
            end
        end
    end

endmodule
